//--- bench/exec_mem_tb.sv
`include "pipe_params.svh"

module exec_mem_tb
	import pipe_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NROWS = 32;
	localparam int LIMIT = 4 * NROWS + 50;

	typedef struct packed
	{
		op_t       op_a;
		reg_addr_t dest_a;
		word_t     a_a;
		word_t     b_a;
		word_t     imm_a;
		op_t       op_b;
		reg_addr_t dest_b;
		word_t     a_b;
		word_t     b_b;
		word_t     tag;
		logic      hold;
		logic      flush;
	} row_t;

	logic clk;
	logic reset;
	logic flush;
	logic hold;
	issue_t issue_a;
	issue_t issue_b;
	logic issue_ready;
	pipe_data_t wb_data_a;
	pipe_data_t wb_data_b;
	reg_wr_t wb_wr_a;
	reg_wr_t wb_wr_b;

	row_t  rows [NROWS];
	word_t model_mem [`DMEM_WORDS];
	int    pending [$]; // row index of pairs in flight
	int    acc_q [$];
	int    hold_q [$];
	int    n_rows;
	int    cur;
	int    drv_row;
	int    cycles;
	int    edge_count;
	int    hold_count;
	int    low_run;
	logic  in_exec;
	logic  mul_accepted;
	integer seed;
	pipe_data_t snap_data_a;
	pipe_data_t snap_data_b;
	reg_wr_t    snap_wr_a;
	reg_wr_t    snap_wr_b;

	exec_mem_top exec_mem_top_inst (
		.clk         (clk),
		.reset       (reset),
		.flush       (flush),
		.hold        (hold),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.issue_ready (issue_ready),
		.wb_data_a   (wb_data_a),
		.wb_data_b   (wb_data_b),
		.wb_wr_a     (wb_wr_a),
		.wb_wr_b     (wb_wr_b)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin
		cycles = 0;
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycles > LIMIT)
			begin
				$display("timeout: the pipeline did not finish within %0d cycles", LIMIT);
				$display("Some tests failed");
				$fatal(1);
			end
		end
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic add_row(input op_t oa, input reg_addr_t da, input word_t aa, input word_t ba,
		input word_t ia, input op_t ob, input reg_addr_t db, input word_t ab, input word_t bb,
		input logic h, input logic f);
		row_t r;
		r = '{oa, da, aa, ba, ia, ob, db, ab, bb, 32'h100 + 32'(n_rows * 2), h, f};
		rows[n_rows] = r;
		n_rows++;
	endtask

	function automatic op_t rand_alu_op(input word_t v);
		return op_t'(4'(1 + (v % 7))); // ADD .. SLL
	endfunction

	// expected writeback of one lane
	task automatic expect_lane(input op_t op, input word_t a, input word_t b, input word_t imm,
		input logic lane_a, output logic valid, output logic we, output word_t wdata);
		word_t addr;
		addr = a + imm;
		valid = (op != OP_NOP);
		we = 1'b1;
		wdata = '0;
		case (op)
			OP_NOP: we = 1'b0;
			OP_ADD: wdata = a + b;
			OP_SUB: wdata = a - b;
			OP_AND: wdata = a & b;
			OP_OR:  wdata = a | b;
			OP_XOR: wdata = a ^ b;
			OP_SLT: wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_SLL: wdata = a << b[4:0];
			OP_MUL: wdata = a * b;
			OP_LW:  wdata = model_mem[addr[7:2]];
			default:
			begin
				we = 1'b0;
				if (lane_a)
					model_mem[addr[7:2]] = b;
			end
		endcase
	endtask

	task automatic save_writeback();
		snap_data_a = wb_data_a;
		snap_data_b = wb_data_b;
		snap_wr_a = wb_wr_a;
		snap_wr_b = wb_wr_b;
	endtask

	task automatic check_writeback();
		row_t r;
		int acc;
		int hc;
		logic va, wa, vb, wbe;
		word_t da, db;
		op_t op_b_exp;
		int lat;
		if (pending.size() == 0)
			report_failure("a writeback record arrived with no pair outstanding");
		r = rows[pending.pop_front()];
		acc = acc_q.pop_front();
		hc = hold_q.pop_front();
		expect_lane(r.op_a, r.a_a, r.b_a, r.imm_a, 1'b1, va, wa, da);
		expect_lane(r.op_b, r.a_b, r.b_b, '0, 1'b0, vb, wbe, db);
		if (r.op_b == OP_LW || r.op_b == OP_SW)
			op_b_exp = OP_NOP; // lane b has no memory port
		else
			op_b_exp = r.op_b;
		check_val("wb_data_a.valid", 64'(wb_data_a.valid), 64'(va));
		check_val("wb_data_b.valid", 64'(wb_data_b.valid), 64'(vb));
		check_val("wb_wr_a.we", 64'(wb_wr_a.we), 64'(wa));
		check_val("wb_wr_b.we", 64'(wb_wr_b.we), 64'(wbe));
		if (va)
		begin
			check_val("wb_data_a.tag", 64'(wb_data_a.tag), 64'(r.tag));
			check_val("wb_data_a.op", 64'(wb_data_a.op), 64'(r.op_a));
		end
		if (vb)
		begin
			check_val("wb_data_b.tag", 64'(wb_data_b.tag), 64'(r.tag + 1));
			check_val("wb_data_b.op", 64'(wb_data_b.op), 64'(op_b_exp));
		end
		if (wa)
		begin
			check_val("wb_wr_a.waddr", 64'(wb_wr_a.waddr), 64'(r.dest_a));
			check_val("wb_wr_a.wdata", 64'(wb_wr_a.wdata), 64'(da));
		end
		if (wbe)
		begin
			check_val("wb_wr_b.waddr", 64'(wb_wr_b.waddr), 64'(r.dest_b));
			check_val("wb_wr_b.wdata", 64'(wb_wr_b.wdata), 64'(db));
		end
		lat = 2 + ((r.op_a == OP_MUL || r.op_b == OP_MUL) ? 1 : 0) + (hold_count - hc);
		check_val("latency", 64'(edge_count - acc), 64'(lat));
	endtask

	task automatic drive_row(input int i);
		issue_t ia;
		issue_t ib;
		row_t r;
		r = (i >= 0 && i < n_rows) ? rows[i] : '0;
		ia = '{r.op_a != OP_NOP, r.op_a, r.dest_a, r.a_a, r.b_a, r.imm_a, r.tag};
		ib = '{r.op_b != OP_NOP, r.op_b, r.dest_b, r.a_b, r.b_b, '0, r.tag + 1};
		issue_a <= ia;
		issue_b <= ib;
		hold <= r.hold;
		flush <= r.flush;
		drv_row <= (i < n_rows) ? i : -1;
	endtask

	// models one edge, drives the next row and checks at the negedge
	task automatic step();
		logic e_hold, e_flush, e_ready, consumed;
		row_t r;
		@(posedge clk);
		e_hold = hold;
		e_flush = flush;
		e_ready = issue_ready;
		edge_count++;
		if (e_hold)
			hold_count++;
		mul_accepted = 1'b0;
		consumed = 1'b0;
		r = (drv_row >= 0) ? rows[drv_row] : '0;
		if (e_flush)
		begin
			if (in_exec)
			begin
				void'(pending.pop_back());
				void'(acc_q.pop_back());
				void'(hold_q.pop_back());
			end
			in_exec = 1'b0;
			consumed = 1'b1;
		end
		else if (e_ready)
		begin
			in_exec = 1'b0;
			if (drv_row >= 0 && (r.op_a != OP_NOP || r.op_b != OP_NOP))
			begin
				pending.push_back(drv_row);
				acc_q.push_back(edge_count);
				hold_q.push_back(hold_count);
				in_exec = 1'b1;
				mul_accepted = (r.op_a == OP_MUL || r.op_b == OP_MUL);
			end
			consumed = 1'b1;
		end
		else if (r.hold)
			consumed = 1'b1;
		if (consumed && drv_row >= 0)
		begin
			cur++;
			drive_row(cur);
		end
		@(negedge clk);
		if (!e_hold && (wb_data_a.valid || wb_data_b.valid))
			check_writeback();
		if (e_hold)
		begin
			check_val("wb_data_a", 64'(wb_data_a), 64'(snap_data_a));
			check_val("wb_data_b", 64'(wb_data_b), 64'(snap_data_b));
			check_val("wb_wr_a", 64'(wb_wr_a), 64'(snap_wr_a));
			check_val("wb_wr_b", 64'(wb_wr_b), 64'(snap_wr_b));
		end
		if (hold)
			check_val("issue_ready", 64'(issue_ready), 64'd0);
		if (mul_accepted && !hold)
			check_val("issue_ready", 64'(issue_ready), 64'd0);
		if (!issue_ready && !hold)
			low_run++;
		else
			low_run = 0;
		if (low_run > 1)
			report_failure("issue_ready stayed low for more than one cycle without hold");
		save_writeback();
	endtask

	initial
	begin
		word_t v [4];
		seed = 32'h9184453d;
		reset = 1'b1;
		flush = 1'b0;
		hold = 1'b0;
		issue_a = '0;
		issue_b = '0;
		n_rows = 0;
		drv_row = -1;
		edge_count = 0;
		hold_count = 0;
		low_run = 0;
		in_exec = 1'b0;

		add_row(OP_ADD, 5'd1, 32'd10, 32'd32, '0, OP_SUB, 5'd2, 32'd5, 32'd9, 1'b0, 1'b0);
		add_row(OP_AND, 5'd3, 32'hf0f0, 32'hff00, '0, OP_OR, 5'd4, 32'h0f, 32'hf000, 1'b0, 1'b0);
		add_row(OP_XOR, 5'd5, 32'haaaa, 32'h5555, '0, OP_SLT, 5'd6, 32'hfffffffe, 32'd3, 1'b0, 1'b0);
		add_row(OP_SLL, 5'd7, 32'h3, 32'h24, '0, OP_SLT, 5'd8, 32'd7, 32'hffffffff, 1'b0, 1'b0);
		repeat (8)
		begin
			for (int k = 0; k < 4; k++)
				v[k] = $random(seed);
			add_row(rand_alu_op(v[0]), 5'(v[1]), v[1], v[2], '0,
				rand_alu_op(v[2]), 5'(v[3]), v[3], v[0], 1'b0, 1'b0);
		end
		add_row(OP_SW, 5'd0, 32'd0, 32'hdeadbeef, 32'd0, OP_ADD, 5'd9, 32'd1, 32'd2, 1'b0, 1'b0);
		add_row(OP_SW, 5'd0, 32'd8, 32'h12345678, 32'd4, OP_OR, 5'd10, 32'd1, 32'd6, 1'b0, 1'b0);
		add_row(OP_SW, 5'd0, 32'd16, 32'hcafe0005, 32'd4, OP_NOP, 5'd0, '0, '0, 1'b0, 1'b0);
		add_row(OP_LW, 5'd11, 32'd0, '0, 32'd0, OP_ADD, 5'd12, 32'd3, 32'd4, 1'b0, 1'b0);
		add_row(OP_LW, 5'd13, 32'd4, '0, 32'd8, OP_XOR, 5'd14, 32'd3, 32'd5, 1'b0, 1'b0);
		add_row(OP_LW, 5'd15, 32'd20, '0, 32'd0, OP_NOP, 5'd0, '0, '0, 1'b0, 1'b0);
		add_row(OP_MUL, 5'd16, 32'h12345, 32'h6789, '0, OP_ADD, 5'd17, 32'd8, 32'd8, 1'b0, 1'b0);
		add_row(OP_SUB, 5'd18, 32'd1, 32'd2, '0, OP_NOP, 5'd0, '0, '0, 1'b0, 1'b0);
		add_row(OP_AND, 5'd19, 32'hff, 32'h0f, '0, OP_MUL, 5'd20, 32'hfffffffd, 32'd7, 1'b0, 1'b0);
		add_row(OP_ADD, 5'd21, 32'd100, 32'd1, '0, OP_SUB, 5'd22, 32'd0, 32'd1, 1'b0, 1'b0);
		repeat (4)
			add_row(OP_NOP, 5'd0, '0, '0, '0, OP_NOP, 5'd0, '0, '0, 1'b1, 1'b0);
		add_row(OP_OR, 5'd23, 32'h10, 32'h01, '0, OP_AND, 5'd24, 32'h33, 32'h0f, 1'b0, 1'b0);
		add_row(OP_XOR, 5'd25, 32'h1, 32'h3, '0, OP_ADD, 5'd26, 32'd40, 32'd2, 1'b0, 1'b0);
		add_row(OP_SW, 5'd0, 32'd0, 32'h0bad0bad, 32'd0, OP_ADD, 5'd27, 32'd5, 32'd5, 1'b0, 1'b0);
		add_row(OP_NOP, 5'd0, '0, '0, '0, OP_NOP, 5'd0, '0, '0, 1'b0, 1'b1);
		add_row(OP_LW, 5'd28, 32'd0, '0, 32'd0, OP_SUB, 5'd29, 32'd9, 32'd4, 1'b0, 1'b0);
		add_row(OP_ADD, 5'd30, 32'd7, 32'd8, '0, OP_SLT, 5'd31, 32'd2, 32'd1, 1'b0, 1'b0);

		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_val("wb_data_a.valid", 64'(wb_data_a.valid), 64'd0);
		check_val("wb_data_b.valid", 64'(wb_data_b.valid), 64'd0);
		check_val("wb_wr_a.we", 64'(wb_wr_a.we), 64'd0);
		check_val("wb_wr_b.we", 64'(wb_wr_b.we), 64'd0);
		check_val("issue_ready", 64'(issue_ready), 64'd1);
		save_writeback();

		@(posedge clk);
		cur = 0;
		drive_row(0);
		while (cur < n_rows || pending.size() > 0)
			step();
		repeat (4)
			step(); // nothing may follow the last record
		$display("All tests passed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+source
source/pipe_pkg.sv
source/stall_ctrl.sv
source/exec_stage.sv
source/ex_mem.sv
source/mem_stage.sv
source/exec_mem_top.sv
bench/exec_mem_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module exec_mem_tb -o exec_mem_sim

output=$(./obj_dir/exec_mem_sim || true)
echo "$output"

if echo "$output" | grep -q "All tests passed"; then
	exit 0
else
	exit 1
fi

//--- source/ex_mem.sv
module ex_mem
	import pipe_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       flush,
	input  stall_t     stall,
	input  pipe_data_t ex_data_a,
	input  pipe_data_t ex_data_b,
	input  pipe_req_t  ex_req_a,
	input  pipe_req_t  ex_req_b,
	output pipe_data_t mem_data_a,
	output pipe_data_t mem_data_b,
	output pipe_req_t  mem_req_a,
	output pipe_req_t  mem_req_b
);

	logic bubble;

	// execute stalled while memory moves on
	assign bubble = stall.stall_ex && !stall.stall_mem;

	always_ff @(posedge clk)
	begin
		if (reset || flush || bubble)
		begin
			mem_data_a.valid <= 1'b0;
			mem_data_a.op    <= OP_NOP;
			mem_data_a.tag   <= '0;
			mem_data_b.valid <= 1'b0;
			mem_data_b.op    <= OP_NOP;
			mem_data_b.tag   <= '0;
			mem_req_a <= '0;
			mem_req_b <= '0;
		end
		else if (!stall.stall_ex)
		begin
			mem_data_a <= ex_data_a;
			mem_data_b <= ex_data_b;
			mem_req_a  <= ex_req_a;
			mem_req_b  <= ex_req_b;
		end
		// full stall holds
	end

endmodule

//--- source/exec_mem_top.sv
module exec_mem_top
	import pipe_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       flush,
	input  logic       hold,
	input  issue_t     issue_a,
	input  issue_t     issue_b,
	output logic       issue_ready,
	output pipe_data_t wb_data_a,
	output pipe_data_t wb_data_b,
	output reg_wr_t    wb_wr_a,
	output reg_wr_t    wb_wr_b
);

	stall_t     stall;
	logic       mul_busy;
	pipe_data_t ex_data_a;
	pipe_data_t ex_data_b;
	pipe_req_t  ex_req_a;
	pipe_req_t  ex_req_b;
	pipe_data_t mem_data_a;
	pipe_data_t mem_data_b;
	pipe_req_t  mem_req_a;
	pipe_req_t  mem_req_b;

	exec_stage exec_stage_inst (
		.clk       (clk),
		.reset     (reset),
		.flush     (flush),
		.stall     (stall),
		.issue_a   (issue_a),
		.issue_b   (issue_b),
		.ex_data_a (ex_data_a),
		.ex_data_b (ex_data_b),
		.ex_req_a  (ex_req_a),
		.ex_req_b  (ex_req_b),
		.mul_busy  (mul_busy)
	);

	stall_ctrl stall_ctrl_inst (
		.hold        (hold),
		.mul_busy    (mul_busy),
		.stall       (stall),
		.issue_ready (issue_ready)
	);

	ex_mem ex_mem_inst (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.stall      (stall),
		.ex_data_a  (ex_data_a),
		.ex_data_b  (ex_data_b),
		.ex_req_a   (ex_req_a),
		.ex_req_b   (ex_req_b),
		.mem_data_a (mem_data_a),
		.mem_data_b (mem_data_b),
		.mem_req_a  (mem_req_a),
		.mem_req_b  (mem_req_b)
	);

	// writeback is not flushed
	mem_stage mem_stage_inst (
		.clk        (clk),
		.reset      (reset),
		.stall      (stall),
		.mem_data_a (mem_data_a),
		.mem_data_b (mem_data_b),
		.mem_req_a  (mem_req_a),
		.mem_req_b  (mem_req_b),
		.wb_data_a  (wb_data_a),
		.wb_data_b  (wb_data_b),
		.wb_wr_a    (wb_wr_a),
		.wb_wr_b    (wb_wr_b)
	);

endmodule

//--- source/exec_stage.sv
module exec_stage
	import pipe_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       flush,
	input  stall_t     stall,
	input  issue_t     issue_a,
	input  issue_t     issue_b,
	output pipe_data_t ex_data_a,
	output pipe_data_t ex_data_b,
	output pipe_req_t  ex_req_a,
	output pipe_req_t  ex_req_b,
	output logic       mul_busy
);

	issue_t     iss_q [2];
	word_t      prod_q [2];
	logic       mul_second;
	logic       mul_pending;
	pipe_data_t data_out [2];
	pipe_req_t  req_out [2];

	function automatic word_t alu(input op_t op, input word_t a, input word_t b);
		word_t r;
		case (op)
			OP_ADD:  r = a + b;
			OP_SUB:  r = a - b;
			OP_AND:  r = a & b;
			OP_OR:   r = a | b;
			OP_XOR:  r = a ^ b;
			OP_SLT:  r = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
			OP_SLL:  r = a << b[4:0];
			default: r = '0;
		endcase
		return r;
	endfunction

	// issue register
	always_ff @(posedge clk)
	begin
		if (reset || flush)
		begin
			iss_q[0] <= '0;
			iss_q[1] <= '0;
		end
		else if (!stall.stall_ex)
		begin
			iss_q[0] <= issue_a;
			iss_q[1] <= issue_b;
		end
	end

	assign mul_pending = (iss_q[0].valid && iss_q[0].op == OP_MUL) ||
		(iss_q[1].valid && iss_q[1].op == OP_MUL);
	assign mul_busy = mul_pending && !mul_second;

	// second multiply cycle, kept until the pair leaves execute
	always_ff @(posedge clk)
	begin
		if (reset || flush)
			mul_second <= 1'b0;
		else if (mul_busy)
			mul_second <= 1'b1;
		else if (!stall.stall_ex)
			mul_second <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (mul_busy)
		begin
			for (int i = 0; i < 2; i++)
				prod_q[i] <= iss_q[i].src_a * iss_q[i].src_b; // low word only
		end
	end

	always_comb
	begin
		for (int i = 0; i < 2; i++)
		begin
			data_out[i] = '0;
			req_out[i] = '0;
			if (iss_q[i].valid)
			begin
				data_out[i].valid = 1'b1;
				data_out[i].op = iss_q[i].op;
				data_out[i].tag = iss_q[i].tag;
				req_out[i].reg_wr.waddr = iss_q[i].dest;
				case (iss_q[i].op)
					OP_NOP: ;
					OP_MUL:
					begin
						req_out[i].reg_wr.we = 1'b1;
						req_out[i].reg_wr.wdata = prod_q[i];
					end
					OP_LW, OP_SW:
					begin
						if (i == 0)
						begin
							req_out[i].memory_req.ce = 1'b1;
							req_out[i].memory_req.we = (iss_q[i].op == OP_SW);
							req_out[i].memory_req.addr = iss_q[i].src_a + iss_q[i].imm;
							req_out[i].memory_req.wdata = iss_q[i].src_b;
							req_out[i].reg_wr.we = (iss_q[i].op == OP_LW); // data from mem stage
						end
						else
							data_out[i].op = OP_NOP; // lane b has no memory port
					end
					default:
					begin
						req_out[i].reg_wr.we = 1'b1;
						req_out[i].reg_wr.wdata = alu(iss_q[i].op, iss_q[i].src_a, iss_q[i].src_b);
					end
				endcase
			end
		end
	end

	assign ex_data_a = data_out[0];
	assign ex_data_b = data_out[1];
	assign ex_req_a  = req_out[0];
	assign ex_req_b  = req_out[1];

endmodule

//--- source/mem_stage.sv
`include "pipe_params.svh"

module mem_stage
	import pipe_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  stall_t     stall,
	input  pipe_data_t mem_data_a,
	input  pipe_data_t mem_data_b,
	input  pipe_req_t  mem_req_a,
	input  pipe_req_t  mem_req_b,
	output pipe_data_t wb_data_a,
	output pipe_data_t wb_data_b,
	output reg_wr_t    wb_wr_a,
	output reg_wr_t    wb_wr_b
);

	word_t               dmem [`DMEM_WORDS];
	logic [`DMEM_AW-1:0] idx;
	logic                is_load;
	logic                is_store;
	reg_wr_t             wr_a;

	assign idx = mem_req_a.memory_req.addr[`DMEM_AW+1:2]; // word index

	assign is_load  = mem_req_a.memory_req.ce && !mem_req_a.memory_req.we;
	assign is_store = mem_req_a.memory_req.ce && mem_req_a.memory_req.we;

	// async read
	always_comb
	begin
		wr_a = mem_req_a.reg_wr;
		if (is_load)
			wr_a.wdata = dmem[idx];
	end

	// contents survive reset
	always_ff @(posedge clk)
	begin
		if (is_store && !stall.stall_mem)
			dmem[idx] <= mem_req_a.memory_req.wdata;
	end

	// writeback register
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wb_data_a <= '0;
			wb_data_b <= '0;
			wb_wr_a   <= '0;
			wb_wr_b   <= '0;
		end
		else if (!stall.stall_mem)
		begin
			wb_data_a <= mem_data_a;
			wb_data_b <= mem_data_b;
			wb_wr_a   <= wr_a;
			wb_wr_b   <= mem_req_b.reg_wr; // no memory path on lane b
		end
	end

endmodule

//--- source/pipe_params.svh
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// datapath
`define DATA_W      32
`define RADDR_W     5

// data memory, word addressed
`define DMEM_WORDS  64
`define DMEM_AW     6

`endif

//--- source/pipe_pkg.sv
`include "pipe_params.svh"

package pipe_pkg;

	typedef logic [`DATA_W-1:0]  word_t;
	typedef logic [`RADDR_W-1:0] reg_addr_t;

	typedef enum logic [3:0]
	{
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_SLL,
		OP_MUL,
		OP_LW,
		OP_SW
	} op_t;

	// decoded instruction with operands, one lane
	typedef struct packed
	{
		logic      valid;
		op_t       op;
		reg_addr_t dest;
		word_t     src_a;
		word_t     src_b;
		word_t     imm;
		word_t     tag; // sequence number, travels to writeback
	} issue_t;

	typedef struct packed
	{
		logic  valid;
		op_t   op;
		word_t tag;
	} pipe_data_t;

	typedef struct packed
	{
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} reg_wr_t;

	typedef struct packed
	{
		logic  ce;
		logic  we;
		word_t addr; // byte address
		word_t wdata;
	} mem_req_t;

	typedef struct packed
	{
		reg_wr_t  reg_wr;
		mem_req_t memory_req;
	} pipe_req_t;

	typedef struct packed
	{
		logic stall_ex;
		logic stall_mem;
	} stall_t;

endpackage

//--- source/stall_ctrl.sv
module stall_ctrl
	import pipe_pkg::*;
(
	input  logic   hold,
	input  logic   mul_busy,
	output stall_t stall,
	output logic   issue_ready
);

	// multiplier only stalls execute, the mem stage keeps draining
	assign stall.stall_ex  = hold | mul_busy;
	assign stall.stall_mem = hold;

	assign issue_ready = ~stall.stall_ex;

endmodule
